// File: proc.f
+incdir+rtl
rtl/procPkg.sv
rtl/ctrlPkg.sv
rtl/ctrlIf.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execution.sv
rtl/memory.sv
rtl/writeback.sv
rtl/proc.sv
verification/proc_properties.sv
verification/tb_proc.sv

// File: Makefile
# Verilator build and run for the single-cycle core
VERILATOR ?= verilator
TOP       ?= tb_proc
SEED      ?= 59
FILELIST  ?= proc.f
BUILD     ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: verification/tb_proc.sv
// Directed tests for the single-cycle core with an instruction driver,
// a reference model of registers and data memory, and a per-test report
`timescale 1ns/1ns
`include "proc_cfg.svh"

module tb_proc;
   import procPkg::*;

   // Two resets plus every instruction the tests issue
   localparam int NUM_CYCLES = 2 * 10 + 48;

   logic   clk = 1'b0;
   logic   rstN;
   wordT   instr, pc, wbData;
   logic   halt, err, wbEn;
   regIdxT wbReg;

   wordT regs [`NUM_REGS];   // Reference register file
   wordT dmem [`DMEM_DEPTH];
   logic halted;
   int   seed = 59;
   int   errors = 0;
   int   testStart = 0;
   int   numTests = 0;

   proc uut (.*);

   always #50 clk = ~clk;

   initial begin
      #((NUM_CYCLES + 20) * 100);
      $display("watchdog expired at %0t, run stopped", $time);
      $display("tests failed");
      $finish;
   end

   function automatic wordT encode(input logic [4:0] op, input regIdxT rs,
                                   input logic [7:0] low);
      return {op, rs, low};   // J takes its imm11 from rs and low
   endfunction

   task automatic checkVal(input string name, input wordT got, input wordT exp);
      assert (got === exp) else begin
         $display("error %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic endTest(input string name);
      $display("%s test finished, %0d errors", name, errors - testStart);
      testStart = errors;
      numTests++;
   endtask

   task automatic applyReset();
      rstN  = 1'b0;
      instr = encode(OP_LBI, 3'd1, 8'h7f);   // Must not commit during reset
      repeat (9) @(posedge clk);
      #1;
      checkVal("wbEn", wordT'(wbEn), '0);
      @(posedge clk);
      #1;
      rstN   = 1'b1;
      instr  = encode(OP_NOP, 3'd0, 8'd0);
      regs   = '{default: '0};
      halted = 1'b0;
      checkVal("pc", pc, wordT'(`RESET_PC));
      checkVal("halt", wordT'(halt), '0);
      checkVal("err", wordT'(err), '0);
   endtask

   // Predicts one instruction, drives it and checks commit, err and next PC
   task automatic runInstr(input wordT ins);
      logic [4:0] op;
      wordT       a, b, i8, ea, res, expPc;
      regIdxT     dst;
      logic       wr, bad;
      op    = ins[15:11];
      a     = regs[ins[10:8]];
      b     = regs[ins[7:5]];
      i8    = {{8{ins[7]}}, ins[7:0]};
      ea    = a + {{11{ins[4]}}, ins[4:0]};
      expPc = pc + 16'd2;
      res   = '0;
      dst   = (op == OP_LBI) ? ins[10:8] :
              (op inside {OP_ADDI, OP_LD}) ? ins[7:5] : ins[4:2];
      bad   = (op inside {OP_LD, OP_ST}) && ea[0];   // Odd byte address
      wr    = (op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SEQ, OP_SLT,
                          OP_ADDI, OP_LBI, OP_LD}) && !bad;
      case (op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_AND:  res = a & b;
         OP_XOR:  res = a ^ b;
         OP_SEQ:  res = (a == b) ? 16'd1 : 16'd0;
         OP_SLT:  res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
         OP_ADDI: res = ea;
         OP_LBI:  res = i8;
         OP_LD:   res = dmem[ea[8:1]];
         OP_ST:   if (!bad && !halted) dmem[ea[8:1]] = b;
         OP_BEQZ: if (a == '0) expPc = expPc + i8;
         OP_BNEZ: if (a != '0) expPc = expPc + i8;
         OP_J:    expPc = expPc + {{5{ins[10]}}, ins[10:0]};
         OP_NOP, OP_HALT: ;
         default: bad = 1'b1;   // Unused opcode
      endcase
      if (halted) begin
         wr    = 1'b0;
         bad   = 1'b0;
         expPc = pc;
      end
      instr = ins;
      #98;   // Just before the next edge
      checkVal("wbEn", wordT'(wbEn), wordT'(wr));
      checkVal("err", wordT'(err), wordT'(bad));
      checkVal("halt", wordT'(halt), wordT'(halted));
      if (wr) begin
         checkVal("wbReg", wordT'(wbReg), wordT'(dst));
         checkVal("wbData", wbData, res);
      end
      @(posedge clk);
      #1;
      checkVal("pc", pc, expPc);
      if (wr) regs[dst] = res;
      if (op == OP_HALT) halted = 1'b1;
   endtask

   task automatic resetAndAdvance();
      applyReset();
      repeat (3) runInstr(encode(OP_NOP, 3'd0, 8'd0));
      endTest("reset");
   endtask

   task automatic aluOperations();
      logic [4:0] ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SEQ, OP_SLT, OP_ADDI};
      for (int r = 0; r < `NUM_REGS; r++) begin
         runInstr(encode(OP_LBI, 3'(r), 8'($random(seed))));
      end
      repeat (2) begin
         foreach (ops[i]) begin
            runInstr(encode(ops[i], 3'($random(seed)), 8'($random(seed))));
         end
      end
      runInstr(encode(OP_SEQ, 3'd3, {3'd3, 3'd4, 2'b00}));   // Equal operands
      endTest("alu");
   endtask

   task automatic storeAndLoad();
      runInstr(encode(OP_LBI, 3'd1, 8'($random(seed)) & 8'hfe));   // Even base
      runInstr(encode(OP_LBI, 3'd2, 8'($random(seed)) | 8'h01));   // Odd data
      runInstr(encode(OP_ST, 3'd1, {3'd2, 5'd4}));
      runInstr(encode(OP_LD, 3'd1, {3'd3, 5'd4}));
      runInstr(encode(OP_ST, 3'd1, {3'd1, 5'd5}));   // Odd address in the same word
      runInstr(encode(OP_LD, 3'd1, {3'd6, 5'd5}));
      runInstr(encode(OP_LD, 3'd1, {3'd7, 5'd4}));   // Still the first store
      endTest("memory");
   endtask

   task automatic branchAndJump();
      runInstr(encode(OP_LBI, 3'd1, 8'd0));
      runInstr(encode(OP_LBI, 3'd2, 8'h5a));
      runInstr(encode(OP_BEQZ, 3'd1, 8'd6));
      runInstr(encode(OP_BEQZ, 3'd2, 8'd6));
      runInstr(encode(OP_BNEZ, 3'd2, 8'hf8));   // Backwards
      runInstr(encode(OP_BNEZ, 3'd1, 8'h10));
      runInstr(encode(OP_J, 3'd2, 8'h00));
      runInstr(encode(OP_J, 3'd7, 8'hf0));      // imm11 of -16
      endTest("branch");
   endtask

   task automatic illegalOpcodes();
      runInstr(encode(5'b11111, 3'd1, {3'd2, 3'd3, 2'b00}));
      runInstr(encode(5'b00010, 3'd4, 8'h25));
      endTest("illegal");
   endtask

   task automatic haltAndRestart();
      runInstr(encode(OP_HALT, 3'd0, 8'd0));
      runInstr(encode(OP_LBI, 3'd1, 8'h11));
      runInstr(encode(OP_ADD, 3'd1, {3'd2, 3'd3, 2'b00}));
      runInstr(encode(5'b11111, 3'd0, 8'd0));   // No err once halted
      applyReset();
      runInstr(encode(OP_NOP, 3'd0, 8'd0));
      endTest("halt");
   endtask

   initial begin
      rstN  = 1'b0;
      instr = encode(OP_NOP, 3'd0, 8'd0);
      resetAndAdvance();
      aluOperations();
      storeAndLoad();
      branchAndJump();
      illegalOpcodes();
      haltAndRestart();
      $display("%0d tests run, %0d errors", numTests, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: verification/proc_properties.sv
// Bound concurrent checks for the core: reset state,
// PC hold and blocked commits while halted or in error
`timescale 1ns/1ns
`include "proc_cfg.svh"

module procProperties (
   input logic          clk,
   input logic          rstN,
   input procPkg::wordT pc,
   input logic          halt,
   input logic          err,
   input logic          wbEn
);
   import procPkg::*;

   resetState: assert property (
      @(posedge clk) $rose(rstN) |-> (pc == wordT'(`RESET_PC)) && !halt
   ) else $error("pc or halt wrong after reset");

   haltHoldsPc: assert property (
      @(posedge clk) disable iff (!rstN) halt |=> $stable(pc)
   ) else $error("pc moved while halted");

   haltNoCommit: assert property (@(posedge clk) halt |-> !wbEn)
      else $error("register write while halted");

   // Both traps must suppress the commit
   errNoCommit: assert property (@(posedge clk) err |-> !wbEn)
      else $error("register write in an error cycle");

endmodule

bind proc procProperties props (
   .clk(clk), .rstN(rstN), .pc(pc), .halt(halt), .err(err), .wbEn(wbEn)
);

// File: rtl/proc.sv
// Single-cycle core top level
// Stages connect through the control interface and plain wires
`timescale 1ns/1ns

module proc (
   input  logic            clk,
   input  logic            rstN,
   input  procPkg::wordT   instr,
   output procPkg::wordT   pc,
   output logic            halt,
   output logic            err,
   output logic            wbEn,
   output procPkg::regIdxT wbReg,
   output procPkg::wordT   wbData
);
   import procPkg::*;

   wordT pcPlusTwo;
   wordT nextPc;
   wordT aluOut;
   wordT memReadData;
   logic halted;
   logic dump;
   logic decErr, memErr;

   ctrlIf ctrlBus ();

   fetch fetch0 (.clk(clk), .rstN(rstN), .nextPc(nextPc), .dump(dump),
                 .pc(pc), .pcPlusTwo(pcPlusTwo), .halted(halted));

   decode decode0 (.instr(instr), .halted(halted), .ctrl(ctrlBus.decodeMp),
                   .dump(dump), .err(decErr));

   execution exec0 (.ctrl(ctrlBus.execMp), .pc(pc), .pcPlusTwo(pcPlusTwo),
                    .aluOut(aluOut), .nextPc(nextPc));

   memory memory0 (.clk(clk), .ctrl(ctrlBus.memMp),
                   .memReadData(memReadData), .err(memErr));

   writeback wb0 (.clk(clk), .rstN(rstN), .ctrl(ctrlBus.wbMp), .aluOut(aluOut),
                  .memReadData(memReadData), .pcPlusTwo(pcPlusTwo),
                  .blockWr(memErr), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData));

   assign halt = halted;
   assign err  = decErr | memErr;   // All stage traps

endmodule

// File: rtl/writeback.sv
// Writeback value select, register file and commit trace
`timescale 1ns/1ns
`include "proc_cfg.svh"

module writeback (
   input  logic            clk,
   input  logic            rstN,
   ctrlIf.wbMp             ctrl,
   input  procPkg::wordT   aluOut,
   input  procPkg::wordT   memReadData,
   input  procPkg::wordT   pcPlusTwo,
   input  logic            blockWr,
   output logic            wbEn,
   output procPkg::regIdxT wbReg,
   output procPkg::wordT   wbData
);
   import procPkg::*;
   import ctrlPkg::*;

   wordT regFile [`NUM_REGS];

   always_comb begin
      case (ctrl.regDataSrc)
         RD_MEM:     wbData = memReadData;
         RD_IMM8:    wbData = ctrl.imm8Ext;
         RD_PCPLUS2: wbData = pcPlusTwo;
         default:    wbData = aluOut;
      endcase
   end

   // Misaligned loads must not commit
   assign wbEn  = ctrl.regWrEn & ~blockWr & rstN;
   assign wbReg = ctrl.writeReg;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         regFile <= '{default: '0};
      end else if (wbEn) begin
         regFile[wbReg] <= wbData;
      end
   end

   assign ctrl.readData1 = regFile[ctrl.rdAddr1];
   assign ctrl.readData2 = regFile[ctrl.rdAddr2];

endmodule

// File: rtl/memory.sv
// Data memory stage: effective address, word RAM, alignment trap
`timescale 1ns/1ns
`include "proc_cfg.svh"

module memory (
   input  logic          clk,
   ctrlIf.memMp          ctrl,
   output procPkg::wordT memReadData,
   output logic          err
);
   import procPkg::*;

   localparam int IDX_W = $clog2(`DMEM_DEPTH);

   wordT             ram [`DMEM_DEPTH];
   wordT             effAddr;
   logic [IDX_W-1:0] wordIdx;

   assign effAddr = ctrl.readData1 + ctrl.imm5Ext;   // Rs + imm5
   assign wordIdx = effAddr[IDX_W:1];
   assign err     = ctrl.memEn & effAddr[0];

   assign memReadData = ram[wordIdx];

   always_ff @(posedge clk) begin
      if (ctrl.memEn && ctrl.memWr && !effAddr[0]) begin
         ram[wordIdx] <= ctrl.readData2;
      end
   end

endmodule

// File: rtl/execution.sv
// ALU with set-condition results and next-PC selection
// for branches and jumps
`timescale 1ns/1ns

module execution (
   ctrlIf.execMp         ctrl,
   input  procPkg::wordT pc,
   input  procPkg::wordT pcPlusTwo,
   output procPkg::wordT aluOut,
   output procPkg::wordT nextPc
);
   import procPkg::*;
   import ctrlPkg::*;

   wordT opA, opB;
   wordT offset;
   logic isZero;
   logic taken;

   assign opA = ctrl.readData1;
   assign opB = (ctrl.aluSrc == SRC_IMM5) ? ctrl.imm5Ext : ctrl.readData2;

   always_comb begin
      case (ctrl.aluOp)
         ALU_ADD: aluOut = opA + opB;
         ALU_SUB: aluOut = opA - opB;
         ALU_AND: aluOut = opA & opB;
         ALU_XOR: aluOut = opA ^ opB;
         ALU_SEQ: aluOut = wordT'(opA == opB);
         ALU_SLT: aluOut = wordT'($signed(opA) < $signed(opB));
         default: aluOut = opB;   // PASSB
      endcase
   end

   // Branch condition tests Rs
   assign isZero = (ctrl.readData1 == '0);
   assign taken  = ctrl.branch & (isZero == ctrl.branchOnZero);

   assign offset = ctrl.jump ? ctrl.imm11Ext : ctrl.imm8Ext;

   // Targets are relative to the following instruction
   always_comb begin
      if (ctrl.jump || taken) begin
         nextPc = pc + offset + wordT'(2);
      end else begin
         nextPc = pcPlusTwo;
      end
   end

endmodule

// File: rtl/decode.sv
// Instruction decoder: control generation, register read addresses,
// immediate sign extension and illegal-opcode trap
`timescale 1ns/1ns
`include "proc_cfg.svh"

module decode (
   input  procPkg::wordT instr,
   input  logic          halted,
   ctrlIf.decodeMp       ctrl,
   output logic          dump,
   output logic          err
);
   import procPkg::*;
   import ctrlPkg::*;

   opcodeE opcode;
   regIdxT rs, rt, rdR;
   imm5T   imm5;
   imm8T   imm8;
   imm11T  imm11;
   logic   illegal;
   logic   isHalt;

   assign opcode = opcodeE'(instr[OPC_LO +: OPC_W]);
   assign rs     = instr[RS_LO +: $bits(regIdxT)];
   assign rt     = instr[RT_LO +: $bits(regIdxT)];
   assign rdR    = instr[RDR_LO +: $bits(regIdxT)];
   assign imm5   = instr[$bits(imm5T)-1:0];
   assign imm8   = instr[$bits(imm8T)-1:0];
   assign imm11  = instr[$bits(imm11T)-1:0];

   assign ctrl.imm5Ext  = {{(`WORD_W-$bits(imm5T)){imm5[$bits(imm5T)-1]}}, imm5};
   assign ctrl.imm8Ext  = {{(`WORD_W-$bits(imm8T)){imm8[$bits(imm8T)-1]}}, imm8};
   assign ctrl.imm11Ext = {{(`WORD_W-$bits(imm11T)){imm11[$bits(imm11T)-1]}}, imm11};

   always_comb begin
      ctrl.aluOp        = ALU_PASSB;
      ctrl.aluSrc       = SRC_REG;
      ctrl.memEn        = 1'b0;
      ctrl.memWr        = 1'b0;
      ctrl.regDataSrc   = RD_ALU;
      ctrl.regWrEn      = 1'b0;
      ctrl.writeReg     = rdR;
      ctrl.branch       = 1'b0;
      ctrl.branchOnZero = 1'b0;
      ctrl.jump         = 1'b0;
      ctrl.rdAddr1      = rs;
      ctrl.rdAddr2      = rt;   // Rt for R-type, store data for ST
      illegal           = 1'b0;
      isHalt            = 1'b0;

      case (opcode)
         OP_NOP:  ;
         OP_HALT: isHalt = 1'b1;
         OP_ADD:  begin ctrl.aluOp = ALU_ADD; ctrl.regWrEn = 1'b1; end
         OP_SUB:  begin ctrl.aluOp = ALU_SUB; ctrl.regWrEn = 1'b1; end
         OP_AND:  begin ctrl.aluOp = ALU_AND; ctrl.regWrEn = 1'b1; end
         OP_XOR:  begin ctrl.aluOp = ALU_XOR; ctrl.regWrEn = 1'b1; end
         OP_SEQ:  begin ctrl.aluOp = ALU_SEQ; ctrl.regWrEn = 1'b1; end
         OP_SLT:  begin ctrl.aluOp = ALU_SLT; ctrl.regWrEn = 1'b1; end
         OP_ADDI: begin
            ctrl.aluOp    = ALU_ADD;
            ctrl.aluSrc   = SRC_IMM5;
            ctrl.regWrEn  = 1'b1;
            ctrl.writeReg = rt;
         end
         OP_LBI: begin
            ctrl.regDataSrc = RD_IMM8;
            ctrl.regWrEn    = 1'b1;
            ctrl.writeReg   = rs;   // imm8 covers the low bits
         end
         OP_LD: begin
            ctrl.memEn      = 1'b1;
            ctrl.regDataSrc = RD_MEM;
            ctrl.regWrEn    = 1'b1;
            ctrl.writeReg   = rt;
         end
         OP_ST: begin
            ctrl.memEn = 1'b1;
            ctrl.memWr = 1'b1;
         end
         OP_BEQZ: begin
            ctrl.branch       = 1'b1;
            ctrl.branchOnZero = 1'b1;
         end
         OP_BNEZ: ctrl.branch = 1'b1;
         OP_J:    ctrl.jump = 1'b1;
         default: illegal = 1'b1;
      endcase

      // Nothing may change state once halted or on a bad opcode
      if (halted || illegal) begin
         ctrl.regWrEn = 1'b0;
         ctrl.memEn   = 1'b0;
         ctrl.memWr   = 1'b0;
      end
   end

   assign dump = isHalt & ~halted;
   assign err  = illegal & ~halted;

endmodule

// File: rtl/fetch.sv
// PC register, sequential PC adder and sticky halt state
`timescale 1ns/1ns
`include "proc_cfg.svh"

module fetch (
   input  logic          clk,
   input  logic          rstN,
   input  procPkg::wordT nextPc,
   input  logic          dump,
   output procPkg::wordT pc,
   output procPkg::wordT pcPlusTwo,
   output logic          halted
);
   import procPkg::*;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc     <= wordT'(`RESET_PC);
         halted <= 1'b0;
      end else if (!halted) begin
         pc     <= nextPc;
         halted <= dump;   // Stays set until reset
      end
   end

   // Instructions are two bytes wide
   assign pcPlusTwo = pc + wordT'(2);

endmodule

// File: rtl/ctrlIf.sv
// Decoded control and register operands shared by decode,
// execution, memory and writeback
`timescale 1ns/1ns

interface ctrlIf;
   import procPkg::*;
   import ctrlPkg::*;

   wordT       readData1, readData2;
   regIdxT     rdAddr1, rdAddr2;
   wordT       imm5Ext, imm8Ext, imm11Ext;
   aluOpE      aluOp;
   aluSrcE     aluSrc;
   logic       memEn, memWr;
   regDataSrcE regDataSrc;
   logic       regWrEn;
   regIdxT     writeReg;
   logic       branch, branchOnZero, jump;

   modport decodeMp (
      input  readData1, readData2,
      output rdAddr1, rdAddr2, imm5Ext, imm8Ext, imm11Ext, aluOp, aluSrc,
      output memEn, memWr, regDataSrc, regWrEn, writeReg,
      output branch, branchOnZero, jump
   );

   modport execMp (
      input readData1, readData2, imm5Ext, imm8Ext, imm11Ext,
      input aluOp, aluSrc, branch, branchOnZero, jump
   );

   modport memMp (
      input readData1, readData2, imm5Ext, memEn, memWr
   );

   // Register file lives in writeback, so read data flows back from here
   modport wbMp (
      input  rdAddr1, rdAddr2, imm8Ext, regDataSrc, regWrEn, writeReg,
      output readData1, readData2
   );

endinterface

// File: rtl/ctrlPkg.sv
// Control encodings produced by decode
package ctrlPkg;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_SEQ,
      ALU_SLT,
      ALU_PASSB
   } aluOpE;

   typedef enum logic {
      SRC_REG,
      SRC_IMM5
   } aluSrcE;

   // Register write value
   typedef enum logic [1:0] {
      RD_ALU,
      RD_MEM,
      RD_IMM8,
      RD_PCPLUS2
   } regDataSrcE;

endpackage

// File: rtl/procPkg.sv
// Architectural types of the core: word, register index,
// opcode encoding and instruction field positions
`include "proc_cfg.svh"

package procPkg;

   typedef logic [`WORD_W-1:0] wordT;
   typedef logic [$clog2(`NUM_REGS)-1:0] regIdxT;

   // Immediate fields sit at the low end of the word
   typedef logic [4:0]  imm5T;
   typedef logic [7:0]  imm8T;
   typedef logic [10:0] imm11T;

   localparam int OPC_W  = 5;
   localparam int OPC_LO = 11;
   localparam int RS_LO  = 8;
   localparam int RT_LO  = 5;   // Also Rd of I-format
   localparam int RDR_LO = 2;   // Rd of R-format

   typedef enum logic [OPC_W-1:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ADD  = 5'b11001,
      OP_SUB  = 5'b11010,
      OP_AND  = 5'b11011,
      OP_XOR  = 5'b11100,
      OP_SEQ  = 5'b11101,
      OP_SLT  = 5'b11110
   } opcodeE;

endpackage

// File: rtl/proc_cfg.svh
// Core sizing macros: word width, register count,
// data memory depth and reset PC
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

`define WORD_W     16
`define NUM_REGS   8
`define DMEM_DEPTH 256   // Words, not bytes
`define RESET_PC   0

`endif
